// File: Bender.yml
package:
  name: vp8_recon

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/vp8_recon_pkg.sv
      - hdl/recon_csr_axil.sv
      - hdl/coeff_dequant.sv
      - hdl/idct4x4_recon.sv
      - hdl/vp8_recon_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_vp8_recon.sv

// File: hdl/coeff_dequant.sv
// Registered dequantizer stage scaling block coefficients by the DC and AC quantizer factors
`timescale 1ns/1ps
`include "vp8_recon_params.svh"

module coeff_dequant
    import vp8_recon_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  coeff_t    [`VP8_BLK_N-1:0]     coeff_i,
    input  pixel_t    [`VP8_BLK_N-1:0]     pred_i,
    input  qfactor_t                       dc_q_i,
    input  qfactor_t                       ac_q_i,
    output logic                           valid_o,
    output dq_coeff_t [`VP8_BLK_N-1:0]     dq_coeff_o,
    output pixel_t    [`VP8_BLK_N-1:0]     pred_o
);

    // Signed coefficient times factor with a sign bit added
    localparam int PROD_W = `VP8_COEFF_W + `VP8_QF_W + 1;

    localparam logic signed [PROD_W-1:0] DQ_MAX = PROD_W'(2 ** (`VP8_DQ_W - 1) - 1);
    localparam logic signed [PROD_W-1:0] DQ_MIN = -DQ_MAX - 1;

    function automatic dq_coeff_t scale_sat(input coeff_t c, input qfactor_t q);
        logic signed [PROD_W-1:0] prod;
        prod = c * $signed({1'b0, q});
        if (prod > DQ_MAX) begin
            return DQ_MAX[`VP8_DQ_W-1:0];
        end else if (prod < DQ_MIN) begin
            return DQ_MIN[`VP8_DQ_W-1:0];
        end
        return prod[`VP8_DQ_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= start_i;
        end
    end

    // Element 0 is DC, the rest are AC
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int k = 0; k < `VP8_BLK_N; k++) begin
                dq_coeff_o[k] <= scale_sat(coeff_i[k], (k == 0) ? dc_q_i : ac_q_i);
            end
            pred_o <= pred_i;
        end
    end

    a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o == $past(start_i))
        else $error("dequant valid out of step with start");

endmodule

// File: hdl/idct4x4_recon.sv
// Two-stage 4x4 inverse DCT adding the prediction block and clamping to 8-bit pixels
`timescale 1ns/1ps
`include "vp8_recon_params.svh"

module idct4x4_recon
    import vp8_recon_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_i,
    input  dq_coeff_t [`VP8_BLK_N-1:0]     coeff_i,
    input  pixel_t    [`VP8_BLK_N-1:0]     pred_i,
    output pixel_t    [`VP8_BLK_N-1:0]     pix_o,
    output logic                           done_o
);

    // sin(pi/8)*sqrt2 and cos(pi/8)*sqrt2 in Q16
    localparam logic signed [18:0] K_S8 = 19'sd35468;
    localparam logic signed [18:0] K_C8 = 19'sd85627;

    // Column results, stored transposed so tmp[4c+k] is row k of column c
    logic signed [18:0] tmp_d [`VP8_BLK_N];
    logic signed [18:0] tmp_q [`VP8_BLK_N];
    pixel_t             pix_d [`VP8_BLK_N];
    pixel_t [`VP8_BLK_N-1:0] pred_q;
    logic               vld_q;

    // Full-width product, then arithmetic shift by 16
    function automatic logic signed [20:0] mul_k(input logic signed [18:0] x,
                                                 input logic signed [18:0] k);
        logic signed [37:0] prod;
        prod = x * k;
        return prod[36:16];
    endfunction

    // Descale by 8, add prediction, clamp to pixel range
    function automatic pixel_t recon_pix(input logic signed [21:0] v, input pixel_t p);
        logic signed [21:0] sum;
        sum = (v >>> 3) + $signed({{(22 - `VP8_PIX_W){1'b0}}, p});
        if (sum > 22'sd255) begin
            return '1;
        end else if (sum < 22'sd0) begin
            return '0;
        end
        return sum[`VP8_PIX_W-1:0];
    endfunction

    // ----------------------------------------
    // First pass on columns
    // ----------------------------------------
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [20:0] a0, a1, a2, a3;

        assign a0 = coeff_i[c] + coeff_i[c + 8];
        assign a1 = coeff_i[c] - coeff_i[c + 8];
        assign a2 = mul_k(coeff_i[c + 4], K_S8) - mul_k(coeff_i[c + 12], K_C8);
        assign a3 = mul_k(coeff_i[c + 4], K_C8) + mul_k(coeff_i[c + 12], K_S8);

        assign tmp_d[4*c + 0] = 19'(a0 + a3);
        assign tmp_d[4*c + 1] = 19'(a1 + a2);
        assign tmp_d[4*c + 2] = 19'(a1 - a2);
        assign tmp_d[4*c + 3] = 19'(a0 - a3);
    end

    // ----------------------------------------
    // Second pass on rows
    // ----------------------------------------
    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [21:0] b0, b1, b2, b3;

        // Rounding term folded into the even part
        assign b0 = tmp_q[r] + tmp_q[r + 8] + 22'sd4;
        assign b1 = tmp_q[r] - tmp_q[r + 8] + 22'sd4;
        assign b2 = mul_k(tmp_q[r + 4], K_S8) - mul_k(tmp_q[r + 12], K_C8);
        assign b3 = mul_k(tmp_q[r + 4], K_C8) + mul_k(tmp_q[r + 12], K_S8);

        assign pix_d[4*r + 0] = recon_pix(b0 + b3, pred_q[4*r + 0]);
        assign pix_d[4*r + 1] = recon_pix(b1 + b2, pred_q[4*r + 1]);
        assign pix_d[4*r + 2] = recon_pix(b1 - b2, pred_q[4*r + 2]);
        assign pix_d[4*r + 3] = recon_pix(b0 - b3, pred_q[4*r + 3]);
    end

    // ----------------------------------------
    // Pipeline registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            vld_q  <= start_i;
            done_o <= vld_q;
        end
    end

    // Prediction moves with its block so each stage holds a different one
    always_ff @(posedge clk) begin
        if (start_i) begin
            tmp_q  <= tmp_d;
            pred_q <= pred_i;
        end
        if (vld_q) begin
            for (int k = 0; k < `VP8_BLK_N; k++) begin
                pix_o[k] <= pix_d[k];
            end
        end
    end

    a_done_delay: assert property (@(posedge clk) disable iff (!rst_n)
        done_o == $past(start_i, 2))
        else $error("idct done out of step with start");

endmodule

// File: hdl/recon_csr_axil.sv
// AXI4-Lite register slave holding DC/AC quantizer factors and the finished-block counter
`timescale 1ns/1ps
`include "vp8_recon_params.svh"

module recon_csr_axil
    import vp8_recon_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    // Write address and data
    input  logic [`AXIL_ADDR_W-1:0]     s_awaddr_i,
    input  logic                        s_awvalid_i,
    output logic                        s_awready_o,
    input  logic [`AXIL_DATA_W-1:0]     s_wdata_i,
    input  logic [`AXIL_DATA_W/8-1:0]   s_wstrb_i,
    input  logic                        s_wvalid_i,
    output logic                        s_wready_o,
    // Write response
    output logic [1:0]                  s_bresp_o,
    output logic                        s_bvalid_o,
    input  logic                        s_bready_i,
    // Read address and data
    input  logic [`AXIL_ADDR_W-1:0]     s_araddr_i,
    input  logic                        s_arvalid_i,
    output logic                        s_arready_o,
    output logic [`AXIL_DATA_W-1:0]     s_rdata_o,
    output logic [1:0]                  s_rresp_o,
    output logic                        s_rvalid_o,
    input  logic                        s_rready_i,
    // Datapath side
    input  logic                        blk_done_i,
    output qfactor_t                    dc_q_o,
    output qfactor_t                    ac_q_o
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    axil_wr_state_e wr_state;
    axil_rd_state_e rd_state;
    logic           wr_fire;
    logic           rd_fire;
    blk_cnt_t       blk_cnt;

    // Bytewise strobe merge, only the low factor bits are kept
    function automatic qfactor_t merge_strb(input qfactor_t old_q,
                                            input logic [`AXIL_DATA_W-1:0] data,
                                            input logic [`AXIL_DATA_W/8-1:0] strb);
        logic [`AXIL_DATA_W-1:0] word;
        word = `AXIL_DATA_W'(old_q);
        for (int b = 0; b < `AXIL_DATA_W / 8; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        return word[`VP8_QF_W-1:0];
    endfunction

    // ----------------------------------------
    // Write channel
    // ----------------------------------------
    // Address and data are taken together in a single cycle
    assign wr_fire     = (wr_state == WR_IDLE) && s_awvalid_i && s_wvalid_i;
    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;
    assign s_bvalid_o  = (wr_state == WR_RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state  <= WR_IDLE;
            s_bresp_o <= RESP_OKAY;
            dc_q_o    <= qfactor_t'(1);
            ac_q_o    <= qfactor_t'(1);
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state  <= WR_RESP;
                        s_bresp_o <= RESP_OKAY;
                        case (s_awaddr_i)
                            `REG_DC_Q: dc_q_o <= merge_strb(dc_q_o, s_wdata_i, s_wstrb_i);
                            `REG_AC_Q: ac_q_o <= merge_strb(ac_q_o, s_wdata_i, s_wstrb_i);
                            // Counter is read-only, write dropped silently
                            `REG_BLK_CNT: ;
                            default: s_bresp_o <= RESP_SLVERR;
                        endcase
                    end
                end
                WR_RESP: begin
                    if (s_bready_i) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Read channel
    // ----------------------------------------
    assign rd_fire     = (rd_state == RD_IDLE) && s_arvalid_i;
    assign s_arready_o = rd_fire;
    assign s_rvalid_o  = (rd_state == RD_DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (rd_fire) rd_state <= RD_DATA;
                RD_DATA: if (s_rready_i) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // Read data captured at the address handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_rresp_o <= RESP_OKAY;
            case (s_araddr_i)
                `REG_DC_Q:    s_rdata_o <= `AXIL_DATA_W'(dc_q_o);
                `REG_AC_Q:    s_rdata_o <= `AXIL_DATA_W'(ac_q_o);
                `REG_BLK_CNT: s_rdata_o <= blk_cnt;
                default: begin
                    s_rdata_o <= '0;
                    s_rresp_o <= RESP_SLVERR;
                end
            endcase
        end
    end

    // Finished blocks, wraps at 32 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_cnt <= '0;
        end else if (blk_done_i) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    // Response held until the master takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o)
        else $error("bvalid dropped without bready");

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
        else $error("rdata changed while stalled");

endmodule

// File: hdl/vp8_recon_pkg.sv
// Vector types and CSR FSM states for the reconstruction path; import with vp8_recon_pkg::*
`include "vp8_recon_params.svh"

package vp8_recon_pkg;

    // ----------------------------------------
    // Datapath element types
    // ----------------------------------------
    // Quantized coefficient as decoded from tokens
    typedef logic signed [`VP8_COEFF_W-1:0] coeff_t;

    // Coefficient after dequantization and saturation
    typedef logic signed [`VP8_DQ_W-1:0] dq_coeff_t;

    typedef logic [`VP8_PIX_W-1:0] pixel_t;

    // Unsigned quantizer step
    typedef logic [`VP8_QF_W-1:0] qfactor_t;

    typedef logic [31:0] blk_cnt_t;

    // ----------------------------------------
    // CSR state machines
    // ----------------------------------------
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } axil_wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } axil_rd_state_e;

endpackage

// File: hdl/vp8_recon_top.sv
// Top of the VP8 residual reconstruction path; instantiate with AXI4-Lite CSRs and block ports
`timescale 1ns/1ps
`include "vp8_recon_params.svh"

module vp8_recon_top
    import vp8_recon_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    // AXI4-Lite configuration slave
    input  logic [`AXIL_ADDR_W-1:0]       s_awaddr_i,
    input  logic                          s_awvalid_i,
    output logic                          s_awready_o,
    input  logic [`AXIL_DATA_W-1:0]       s_wdata_i,
    input  logic [`AXIL_DATA_W/8-1:0]     s_wstrb_i,
    input  logic                          s_wvalid_i,
    output logic                          s_wready_o,
    output logic [1:0]                    s_bresp_o,
    output logic                          s_bvalid_o,
    input  logic                          s_bready_i,
    input  logic [`AXIL_ADDR_W-1:0]       s_araddr_i,
    input  logic                          s_arvalid_i,
    output logic                          s_arready_o,
    output logic [`AXIL_DATA_W-1:0]       s_rdata_o,
    output logic [1:0]                    s_rresp_o,
    output logic                          s_rvalid_o,
    input  logic                          s_rready_i,
    // Block datapath, raster order
    input  logic                          blk_start_i,
    input  coeff_t [`VP8_BLK_N-1:0]       blk_coeff_i,
    input  pixel_t [`VP8_BLK_N-1:0]       blk_pred_i,
    output pixel_t [`VP8_BLK_N-1:0]       blk_pix_o,
    output logic                          blk_done_o
);

    qfactor_t                   dc_q;
    qfactor_t                   ac_q;
    logic                       dq_valid;
    dq_coeff_t [`VP8_BLK_N-1:0] dq_coeff;
    pixel_t    [`VP8_BLK_N-1:0] dq_pred;

    // ----------------------------------------
    // Configuration registers
    // ----------------------------------------
    recon_csr_axil u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .blk_done_i  (blk_done_o),
        .dc_q_o      (dc_q),
        .ac_q_o      (ac_q)
    );

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    coeff_dequant u_dequant (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (blk_start_i),
        .coeff_i    (blk_coeff_i),
        .pred_i     (blk_pred_i),
        .dc_q_i     (dc_q),
        .ac_q_i     (ac_q),
        .valid_o    (dq_valid),
        .dq_coeff_o (dq_coeff),
        .pred_o     (dq_pred)
    );

    idct4x4_recon u_idct (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (dq_valid),
        .coeff_i (dq_coeff),
        .pred_i  (dq_pred),
        .pix_o   (blk_pix_o),
        .done_o  (blk_done_o)
    );

endmodule

// File: include/vp8_recon_params.svh
// Block geometry, field widths and CSR map of the VP8 reconstruction path; include where needed
`ifndef VP8_RECON_PARAMS_SVH
`define VP8_RECON_PARAMS_SVH

// ----------------------------------------
// Block geometry
// ----------------------------------------
// Coefficients or pixels per 4x4 block
`define VP8_BLK_N 16

// ----------------------------------------
// Datapath field widths
// ----------------------------------------
`define VP8_COEFF_W 12
`define VP8_DQ_W 16
`define VP8_PIX_W 8
`define VP8_QF_W 9

// ----------------------------------------
// AXI4-Lite configuration port
// ----------------------------------------
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

// Register offsets
`define REG_DC_Q 4'h0
`define REG_AC_Q 4'h4
`define REG_BLK_CNT 4'h8

`endif

// File: tb.f
+incdir+include
hdl/vp8_recon_pkg.sv
hdl/recon_csr_axil.sv
hdl/coeff_dequant.sv
hdl/idct4x4_recon.sv
hdl/vp8_recon_top.sv
tests/tb_vp8_recon.sv

// File: tests/tb_vp8_recon.sv
// Testbench for vp8_recon_top; drives CSR writes and 4x4 blocks, checks pixels against a model
`timescale 1ns/1ps
`include "vp8_recon_params.svh"

module tb_vp8_recon
    import vp8_recon_pkg::*;
();

    localparam int BLK_BITS  = `VP8_BLK_N * `VP8_PIX_W;
    localparam int COEF_BITS = `VP8_BLK_N * `VP8_COEFF_W;
    localparam int TMO       = 20;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic clk;
    logic rst_n;
    logic [`AXIL_ADDR_W-1:0]   s_awaddr;
    logic                      s_awvalid;
    logic                      s_awready;
    logic [`AXIL_DATA_W-1:0]   s_wdata;
    logic [`AXIL_DATA_W/8-1:0] s_wstrb;
    logic                      s_wvalid;
    logic                      s_wready;
    logic [1:0]                s_bresp;
    logic                      s_bvalid;
    logic                      s_bready;
    logic [`AXIL_ADDR_W-1:0]   s_araddr;
    logic                      s_arvalid;
    logic                      s_arready;
    logic [`AXIL_DATA_W-1:0]   s_rdata;
    logic [1:0]                s_rresp;
    logic                      s_rvalid;
    logic                      s_rready;
    logic                      blk_start;
    logic [COEF_BITS-1:0]      blk_coeff;
    logic [BLK_BITS-1:0]       blk_pred;
    logic [BLK_BITS-1:0]       blk_pix;
    logic                      blk_done;

    // Expected pixels in issue order, and the cycle each start was sampled
    logic [BLK_BITS-1:0] exp_q[$];
    longint              start_q[$];
    longint              cyc = 0;
    int                  n_starts = 0;
    int                  dcq = 1;
    int                  acq = 1;
    logic [31:0]         lfsr = 32'hd3d4670a;

    vp8_recon_top UUT (
        .clk(clk), .rst_n(rst_n),
        .s_awaddr_i(s_awaddr), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
        .s_wdata_i(s_wdata), .s_wstrb_i(s_wstrb), .s_wvalid_i(s_wvalid),
        .s_wready_o(s_wready), .s_bresp_o(s_bresp), .s_bvalid_o(s_bvalid),
        .s_bready_i(s_bready), .s_araddr_i(s_araddr), .s_arvalid_i(s_arvalid),
        .s_arready_o(s_arready), .s_rdata_o(s_rdata), .s_rresp_o(s_rresp),
        .s_rvalid_o(s_rvalid), .s_rready_i(s_rready),
        .blk_start_i(blk_start), .blk_coeff_i(blk_coeff), .blk_pred_i(blk_pred),
        .blk_pix_o(blk_pix), .blk_done_o(blk_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic longint sat_dq(input longint v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    function automatic longint mul_q16(input longint x, input longint k);
        return (x * k) >>> 16;
    endfunction

    function automatic pixel_t clamp_pix(input longint v);
        if (v > 255) return 8'hff;
        if (v < 0) return 8'h00;
        return pixel_t'(v);
    endfunction

    function automatic logic [BLK_BITS-1:0] ref_recon(input logic [COEF_BITS-1:0] cf,
                                                      input logic [BLK_BITS-1:0] pf,
                                                      input int dc_f, input int ac_f);
        coeff_t [`VP8_BLK_N-1:0] c;
        pixel_t [`VP8_BLK_N-1:0] p;
        pixel_t [`VP8_BLK_N-1:0] res;
        longint dq [`VP8_BLK_N];
        longint t [4][4];
        longint e0, e1, o0, o1;
        c = cf;
        p = pf;
        for (int k = 0; k < `VP8_BLK_N; k++) begin
            dq[k] = sat_dq(longint'(c[k]) * ((k == 0) ? dc_f : ac_f));
        end
        // Columns, then rows
        for (int j = 0; j < 4; j++) begin
            e0 = dq[j] + dq[j + 8];
            e1 = dq[j] - dq[j + 8];
            o0 = mul_q16(dq[j + 4], 35468) - mul_q16(dq[j + 12], 85627);
            o1 = mul_q16(dq[j + 4], 85627) + mul_q16(dq[j + 12], 35468);
            t[0][j] = e0 + o1;
            t[1][j] = e1 + o0;
            t[2][j] = e1 - o0;
            t[3][j] = e0 - o1;
        end
        for (int r = 0; r < 4; r++) begin
            e0 = t[r][0] + t[r][2];
            e1 = t[r][0] - t[r][2];
            o0 = mul_q16(t[r][1], 35468) - mul_q16(t[r][3], 85627);
            o1 = mul_q16(t[r][1], 85627) + mul_q16(t[r][3], 35468);
            res[4*r + 0] = clamp_pix(((e0 + o1 + 4) >>> 3) + longint'(p[4*r + 0]));
            res[4*r + 1] = clamp_pix(((e1 + o0 + 4) >>> 3) + longint'(p[4*r + 1]));
            res[4*r + 2] = clamp_pix(((e1 - o0 + 4) >>> 3) + longint'(p[4*r + 2]));
            res[4*r + 3] = clamp_pix(((e0 - o1 + 4) >>> 3) + longint'(p[4*r + 3]));
        end
        return res;
    endfunction

    // Same offset added to every pixel of a DC-only block
    function automatic logic [BLK_BITS-1:0] dc_expect(input coeff_t dc,
                                                      input logic [BLK_BITS-1:0] pf,
                                                      input int dc_f);
        pixel_t [`VP8_BLK_N-1:0] p;
        pixel_t [`VP8_BLK_N-1:0] res;
        longint ofs;
        p = pf;
        ofs = (sat_dq(longint'(dc) * dc_f) + 4) >>> 3;
        for (int k = 0; k < `VP8_BLK_N; k++) begin
            res[k] = clamp_pix(ofs + longint'(p[k]));
        end
        return res;
    endfunction

    function automatic logic [BLK_BITS-1:0] rand_pred();
        pixel_t [`VP8_BLK_N-1:0] p;
        for (int k = 0; k < `VP8_BLK_N; k++) begin
            p[k] = pixel_t'(take_bits(8));
        end
        return p;
    endfunction

    // Mix of full-range and small coefficients
    function automatic logic [COEF_BITS-1:0] rand_coeff();
        coeff_t [`VP8_BLK_N-1:0] c;
        coeff_t v;
        for (int k = 0; k < `VP8_BLK_N; k++) begin
            v = coeff_t'(take_bits(`VP8_COEFF_W));
            if (take_bits(1) == 1) begin
                v = v >>> 5;
            end
            c[k] = v;
        end
        return c;
    endfunction

    // ----------------------------------------
    // AXI4-Lite master tasks
    // ----------------------------------------
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] exp_resp);
        int n;
        @(posedge clk);
        #1;
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = strb;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(s_awready && s_wready)) begin
            n++;
            if (n > TMO) report_fail("Write address and data were never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_bvalid) begin
            n++;
            if (n > TMO) report_fail("No write response arrived");
            @(negedge clk);
        end
        assert (s_bresp == exp_resp)
            else report_fail($sformatf("Fail s_bresp_o exp=%h got=%h", exp_resp, s_bresp));
        @(posedge clk);
        #1;
        s_bready = 1'b0;
    endtask

    // Data is compared only for an OKAY response
    task automatic axil_read_check(input logic [3:0] addr, input logic [31:0] exp_data,
                                   input logic [1:0] exp_resp);
        int n;
        @(posedge clk);
        #1;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!s_arready) begin
            n++;
            if (n > TMO) report_fail("Read address was never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_rvalid) begin
            n++;
            if (n > TMO) report_fail("No read data arrived");
            @(negedge clk);
        end
        assert (s_rresp == exp_resp)
            else report_fail($sformatf("Fail s_rresp_o exp=%h got=%h", exp_resp, s_rresp));
        if (exp_resp == OKAY) begin
            assert (s_rdata == exp_data)
                else report_fail($sformatf("Fail s_rdata_o exp=%h got=%h", exp_data, s_rdata));
        end
        @(posedge clk);
        #1;
        s_rready = 1'b0;
    endtask

    task automatic set_factors(input logic [31:0] dc_f, input logic [31:0] ac_f);
        axil_write(`REG_DC_Q, dc_f, 4'hf, OKAY);
        axil_write(`REG_AC_Q, ac_f, 4'hf, OKAY);
        dcq = int'(dc_f[`VP8_QF_W-1:0]);
        acq = int'(ac_f[`VP8_QF_W-1:0]);
    endtask

    // ----------------------------------------
    // Block stimulus
    // ----------------------------------------
    task automatic issue_block(input logic [COEF_BITS-1:0] c, input logic [BLK_BITS-1:0] p,
                               input logic [BLK_BITS-1:0] exp_pix);
        @(posedge clk);
        #1;
        blk_start = 1'b1;
        blk_coeff = c;
        blk_pred  = p;
        exp_q.push_back(exp_pix);
        n_starts++;
    endtask

    task automatic stop_blocks();
        @(posedge clk);
        #1;
        blk_start = 1'b0;
    endtask

    task automatic drain_blocks();
        int n;
        n = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            n++;
            if (n > TMO) report_fail("Blocks still outstanding, blk_done_o missing");
            @(negedge clk);
        end
    endtask

    // Compare on the falling edge where outputs are stable
    always @(negedge clk) begin : compare_proc
        logic [BLK_BITS-1:0] exp_pix;
        longint              t0;
        cyc++;
        if (rst_n && blk_done) begin
            if (exp_q.size() == 0 || start_q.size() == 0) begin
                report_fail("blk_done_o rose with no block in flight");
            end
            exp_pix = exp_q.pop_front();
            t0 = start_q.pop_front();
            assert (cyc - t0 == 3)
                else report_fail($sformatf("Fail blk_done_o latency exp=%h got=%h", 3, cyc - t0));
            assert (blk_pix == exp_pix)
                else report_fail($sformatf("Fail blk_pix_o exp=%h got=%h", exp_pix, blk_pix));
        end
        if (rst_n && blk_start) begin
            start_q.push_back(cyc);
        end
    end

    initial begin : main_seq
        logic [COEF_BITS-1:0] cf;
        logic [BLK_BITS-1:0]  pf;
        coeff_t               dc;
        rst_n = 1'b0;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        blk_start = 1'b0;
        blk_coeff = '0;
        blk_pred = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Register map, strobes and error responses
        axil_read_check(`REG_DC_Q, 32'h1, OKAY);
        axil_read_check(`REG_AC_Q, 32'h1, OKAY);
        axil_write(`REG_DC_Q, 32'h0000_0a5c, 4'hf, OKAY);
        axil_read_check(`REG_DC_Q, 32'h05c, OKAY);
        axil_write(`REG_DC_Q, 32'hffff_ff01, 4'b0010, OKAY);
        axil_read_check(`REG_DC_Q, 32'h15c, OKAY);
        axil_write(`REG_AC_Q, 32'hffff_ffff, 4'hf, OKAY);
        axil_read_check(`REG_AC_Q, 32'h1ff, OKAY);
        axil_write(4'hc, 32'h7, 4'hf, SLVERR);
        axil_read_check(4'hc, 32'h0, SLVERR);
        axil_read_check(`REG_DC_Q, 32'h15c, OKAY);
        axil_write(`REG_BLK_CNT, 32'h1234, 4'hf, OKAY);
        axil_read_check(`REG_BLK_CNT, 32'h0, OKAY);

        // Zero residual passes the prediction through
        set_factors(take_bits(9), take_bits(9));
        repeat (4) begin
            pf = rand_pred();
            issue_block('0, pf, pf);
        end
        stop_blocks();

        // DC only blocks starting with the two saturating corners
        set_factors(511, take_bits(9));
        pf = rand_pred();
        issue_block(COEF_BITS'(12'h7ff), pf, dc_expect(12'sh7ff, pf, dcq));
        pf = rand_pred();
        issue_block(COEF_BITS'(12'h800), pf, dc_expect(-12'sd2048, pf, dcq));
        stop_blocks();
        set_factors(take_bits(9), take_bits(9));
        repeat (6) begin
            dc = coeff_t'(take_bits(`VP8_COEFF_W));
            pf = rand_pred();
            cf = '0;
            cf[`VP8_COEFF_W-1:0] = dc;
            issue_block(cf, pf, dc_expect(dc, pf, dcq));
            stop_blocks();
        end

        // Random single blocks
        repeat (6) begin
            set_factors(take_bits(9), take_bits(9));
            repeat (3) begin
                cf = rand_coeff();
                pf = rand_pred();
                issue_block(cf, pf, ref_recon(cf, pf, dcq, acq));
                stop_blocks();
            end
        end

        // Back-to-back bursts
        repeat (3) begin
            set_factors(take_bits(9), take_bits(9));
            repeat (8) begin
                cf = rand_coeff();
                pf = rand_pred();
                issue_block(cf, pf, ref_recon(cf, pf, dcq, acq));
            end
            stop_blocks();
        end

        drain_blocks();
        axil_read_check(`REG_BLK_CNT, 32'(n_starts), OKAY);

        if (exp_q.size() == 0 && start_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule
